/* rtl/lc3b_pkg.sv */
package lc3b_pkg;

	localparam int rob_entries = 8;
	localparam int alu_stations = 3;
	localparam int reg_count = 8;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_rob_addr;

	// Opcode field of the ALU formats
	typedef enum logic [3:0] {
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef struct packed {
		logic valid;
		lc3b_rob_addr tag;
		lc3b_word value;
	} cdb_t;

	// Value when ready, otherwise the producing ROB tag
	typedef struct packed {
		logic ready;
		lc3b_rob_addr tag;
		lc3b_word value;
	} operand_t;

	typedef struct packed {
		logic valid;
		lc3b_opcode op;
		operand_t j;
		operand_t k;
		lc3b_rob_addr dest;
	} issue_t;

	typedef struct packed {
		logic valid;
		lc3b_reg dest;
		lc3b_word value;
	} commit_t;

endpackage

/* rtl/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit
	import lc3b_pkg::*;
(
	input logic clk,
	input logic rst_n,
	output logic imem_req,
	output lc3b_word imem_addr,
	input lc3b_word imem_rdata,
	input logic imem_ack,
	input logic take,
	output lc3b_word instr,
	output logic instr_valid
);

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_req,
		fetch_release
	} fetch_state_t;

	fetch_state_t state;
	lc3b_word pc;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= fetch_idle;
			pc <= '0;
			instr_valid <= 1'b0;
		end
		else
		begin
			case (state)
				fetch_idle:
				begin
					// Holding register must be empty before the next request
					if (!instr_valid && !imem_ack)
						state <= fetch_req;
				end
				fetch_req:
				begin
					if (imem_ack)
					begin
						state <= fetch_release;
						pc <= pc + 16'd2;
						instr_valid <= 1'b1;
					end
				end
				fetch_release:
				begin
					// Wait for the memory to drop ack
					if (!imem_ack)
						state <= fetch_idle;
				end
				default:
					state <= fetch_idle;
			endcase
			if (take)
				instr_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == fetch_req && imem_ack)
			instr <= imem_rdata;
	end

	assign imem_req = (state == fetch_req);
	// PC only moves on ack, so the address holds while req is high
	assign imem_addr = pc;

endmodule

/* rtl/issue_control.sv */
`timescale 1ns/100ps

module issue_control
	import lc3b_pkg::*;
(
	input lc3b_word instr,
	input logic instr_valid,
	output logic take,
	input logic [alu_stations-1:0] stations_busy,
	input logic rob_full,
	input lc3b_rob_addr rob_tail,
	input cdb_t cdb,
	output lc3b_reg sr1,
	output lc3b_reg sr2,
	output lc3b_reg dest_ic,
	input operand_t sr1_in,
	input operand_t sr2_in,
	output lc3b_rob_addr rob_sr1_read_addr,
	output lc3b_rob_addr rob_sr2_read_addr,
	input operand_t rob_sr1_in,
	input operand_t rob_sr2_in,
	output issue_t issue,
	output logic [1:0] station_sel,
	output logic rob_alloc,
	output lc3b_reg rob_dest_in
);

	lc3b_opcode op;
	logic imm_form;
	lc3b_word imm5;
	logic station_free;

	// Register file, then finished ROB entry, then a same-cycle CDB match
	function automatic operand_t resolve(operand_t rf, operand_t rob, cdb_t bus);
		operand_t res;
		res = rf;
		if (!rf.ready)
		begin
			if (rob.ready)
			begin
				res.ready = 1'b1;
				res.value = rob.value;
			end
			else if (bus.valid && bus.tag == rf.tag)
			begin
				res.ready = 1'b1;
				res.value = bus.value;
			end
		end
		return res;
	endfunction

	assign op = lc3b_opcode'(instr[15:12]);
	assign dest_ic = instr[11:9];
	assign sr1 = instr[8:6];
	assign sr2 = instr[2:0];
	assign imm_form = instr[5];
	assign imm5 = {{11{instr[4]}}, instr[4:0]};

	// Busy registers name the ROB entry that will produce them
	assign rob_sr1_read_addr = sr1_in.tag;
	assign rob_sr2_read_addr = sr2_in.tag;
	assign rob_dest_in = dest_ic;

	// Lowest free station
	always_comb
	begin
		station_free = 1'b0;
		station_sel = '0;
		for (int i = alu_stations - 1; i >= 0; i--)
		begin
			if (!stations_busy[i])
			begin
				station_free = 1'b1;
				station_sel = 2'(i);
			end
		end
	end

	assign take = instr_valid && station_free && !rob_full;
	assign rob_alloc = take;

	always_comb
	begin
		issue.valid = take;
		issue.op = op;
		issue.dest = rob_tail;
		issue.j = resolve(sr1_in, rob_sr1_in, cdb);
		// NOT becomes XOR with all ones
		if (op == op_not)
			issue.k = '{ready: 1'b1, tag: 3'd0, value: 16'hffff};
		else if (imm_form)
			issue.k = '{ready: 1'b1, tag: 3'd0, value: imm5};
		else
			issue.k = resolve(sr2_in, rob_sr2_in, cdb);
	end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/100ps

module regfile
	import lc3b_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_reg sr1,
	input lc3b_reg sr2,
	input lc3b_reg dest_ic,
	input logic ld_busy,
	input lc3b_rob_addr rob_entry_in,
	output operand_t sr1_out,
	output operand_t sr2_out,
	input commit_t commit,
	input lc3b_rob_addr commit_tag
);

	lc3b_word value [reg_count];
	lc3b_rob_addr tag [reg_count];
	logic [reg_count-1:0] busy;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= '0;
			for (int i = 0; i < reg_count; i++)
			begin
				value[i] <= '0;
				tag[i] <= '0;
			end
		end
		else
		begin
			if (commit.valid)
			begin
				value[commit.dest] <= commit.value;
				// A newer writer keeps the register busy
				if (tag[commit.dest] == commit_tag)
					busy[commit.dest] <= 1'b0;
			end
			// Issue comes last so its busy flag wins
			if (ld_busy)
			begin
				busy[dest_ic] <= 1'b1;
				tag[dest_ic] <= rob_entry_in;
			end
		end
	end

	assign sr1_out = '{ready: !busy[sr1], tag: tag[sr1], value: value[sr1]};
	assign sr2_out = '{ready: !busy[sr2], tag: tag[sr2], value: value[sr2]};

endmodule

/* rtl/alu_rs_unit.sv */
`timescale 1ns/100ps

module alu_rs_unit
	import lc3b_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input issue_t issue,
	input logic [1:0] station_sel,
	input cdb_t cdb_in,
	output logic [alu_stations-1:0] busy_out,
	output cdb_t cdb_out
);

	issue_t station [alu_stations];
	logic [alu_stations-1:0] ready;
	logic grant_valid;
	logic [1:0] grant;
	lc3b_word result;

	always_comb
	begin
		for (int i = 0; i < alu_stations; i++)
			ready[i] = busy_out[i] && station[i].j.ready && station[i].k.ready;
	end

	// Fixed priority, station 0 first
	always_comb
	begin
		grant_valid = 1'b0;
		grant = '0;
		for (int i = alu_stations - 1; i >= 0; i--)
		begin
			if (ready[i])
			begin
				grant_valid = 1'b1;
				grant = 2'(i);
			end
		end
	end

	always_comb
	begin
		case (station[grant].op)
			op_and: result = station[grant].j.value & station[grant].k.value;
			op_not: result = station[grant].j.value ^ station[grant].k.value;
			default: result = station[grant].j.value + station[grant].k.value;
		endcase
	end

	// Station frees on the edge that puts its result on the CDB
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy_out <= '0;
			cdb_out <= '0;
		end
		else
		begin
			if (grant_valid)
				busy_out[grant] <= 1'b0;
			if (issue.valid)
				busy_out[station_sel] <= 1'b1;
			cdb_out.valid <= grant_valid;
			cdb_out.tag <= station[grant].dest;
			cdb_out.value <= result;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < alu_stations; i++)
		begin
			if (issue.valid && station_sel == 2'(i))
				station[i] <= issue;
			else
			begin
				// Snoop the CDB for waiting operands
				if (!station[i].j.ready && cdb_in.valid && cdb_in.tag == station[i].j.tag)
				begin
					station[i].j.ready <= 1'b1;
					station[i].j.value <= cdb_in.value;
				end
				if (!station[i].k.ready && cdb_in.valid && cdb_in.tag == station[i].k.tag)
				begin
					station[i].k.ready <= 1'b1;
					station[i].k.value <= cdb_in.value;
				end
			end
		end
	end

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/100ps

module reorder_buffer
	import lc3b_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic alloc,
	input lc3b_reg dest_in,
	output lc3b_rob_addr tail,
	output logic full,
	input cdb_t cdb,
	input lc3b_rob_addr sr1_read_addr,
	input lc3b_rob_addr sr2_read_addr,
	output operand_t sr1_out,
	output operand_t sr2_out,
	output commit_t commit,
	output lc3b_rob_addr commit_tag
);

	logic [rob_entries-1:0] valid;
	logic [rob_entries-1:0] done;
	lc3b_reg dest [rob_entries];
	lc3b_word value [rob_entries];
	lc3b_rob_addr head;
	logic [$clog2(rob_entries):0] count;
	logic retire;

	assign full = (count == rob_entries);
	assign retire = valid[head] && done[head];

	// Pointers wrap on their own with eight entries
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid <= '0;
			done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (alloc)
			begin
				valid[tail] <= 1'b1;
				done[tail] <= 1'b0;
				tail <= tail + 3'd1;
			end
			if (cdb.valid)
				done[cdb.tag] <= 1'b1;
			if (retire)
			begin
				valid[head] <= 1'b0;
				head <= head + 3'd1;
			end
			count <= count + 4'(alloc) - 4'(retire);
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc)
			dest[tail] <= dest_in;
		if (cdb.valid)
			value[cdb.tag] <= cdb.value;
	end

	// Finished results for issue
	assign sr1_out = '{ready: valid[sr1_read_addr] && done[sr1_read_addr],
		tag: sr1_read_addr, value: value[sr1_read_addr]};
	assign sr2_out = '{ready: valid[sr2_read_addr] && done[sr2_read_addr],
		tag: sr2_read_addr, value: value[sr2_read_addr]};

	// In-order retirement from the head
	assign commit = '{valid: retire, dest: dest[head], value: value[head]};
	assign commit_tag = head;

endmodule

/* rtl/cpu_datapath.sv */
`timescale 1ns/100ps

module cpu_datapath
	import lc3b_pkg::*;
(
	input logic clk,
	input logic rst_n,
	output logic imem_req,
	output lc3b_word imem_addr,
	input lc3b_word imem_rdata,
	input logic imem_ack,
	output commit_t commit
);

	cdb_t cdb;
	lc3b_word instr;
	logic instr_valid;
	logic take;
	logic [alu_stations-1:0] stations_busy;
	logic rob_full;
	lc3b_rob_addr rob_tail;
	lc3b_reg sr1, sr2, dest_ic;
	operand_t rf_sr1, rf_sr2;
	operand_t rob_sr1, rob_sr2;
	lc3b_rob_addr rob_sr1_read_addr, rob_sr2_read_addr;
	issue_t issue;
	logic [1:0] station_sel;
	logic rob_alloc;
	lc3b_reg rob_dest_in;
	lc3b_rob_addr commit_tag;

	fetch_unit fetch_i (
		.clk, .rst_n,
		.imem_req, .imem_addr, .imem_rdata, .imem_ack,
		.take, .instr, .instr_valid
	);

	issue_control issue_i (
		.instr, .instr_valid, .take,
		.stations_busy, .rob_full, .rob_tail, .cdb,
		.sr1, .sr2, .dest_ic,
		.sr1_in(rf_sr1), .sr2_in(rf_sr2),
		.rob_sr1_read_addr, .rob_sr2_read_addr,
		.rob_sr1_in(rob_sr1), .rob_sr2_in(rob_sr2),
		.issue, .station_sel, .rob_alloc, .rob_dest_in
	);

	// Busy flag is set with the tag of the entry being allocated
	regfile regfile_i (
		.clk, .rst_n,
		.sr1, .sr2, .dest_ic,
		.ld_busy(rob_alloc), .rob_entry_in(rob_tail),
		.sr1_out(rf_sr1), .sr2_out(rf_sr2),
		.commit, .commit_tag
	);

	alu_rs_unit alu_rs_i (
		.clk, .rst_n,
		.issue, .station_sel,
		.cdb_in(cdb), .busy_out(stations_busy), .cdb_out(cdb)
	);

	reorder_buffer rob_i (
		.clk, .rst_n,
		.alloc(rob_alloc), .dest_in(rob_dest_in),
		.tail(rob_tail), .full(rob_full), .cdb,
		.sr1_read_addr(rob_sr1_read_addr), .sr2_read_addr(rob_sr2_read_addr),
		.sr1_out(rob_sr1), .sr2_out(rob_sr2),
		.commit, .commit_tag
	);

endmodule

/* test/cpu_datapath_assertions.sv */
`timescale 1ns/100ps

module cpu_datapath_assertions
	import lc3b_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic imem_req,
	input logic imem_ack,
	input lc3b_word imem_addr,
	input cdb_t cdb,
	input commit_t commit,
	input logic [rob_entries-1:0] rob_valid,
	input logic [rob_entries-1:0] rob_done
);

	int fail_count = 0;

	// Core stays quiet while reset is held
	reset_quiet: assert property (@(posedge clk) !rst_n |-> !imem_req && !cdb.valid && !commit.valid)
	else
	begin
		fail_count++;
		$error("Request, CDB or commit active during reset");
	end

	// Four-phase order on the instruction port
	req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(imem_req) |-> !$past(imem_ack))
	else
	begin
		fail_count++;
		$error("imem_req rose while imem_ack was still high");
	end

	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		imem_req && !imem_ack |=> imem_req)
	else
	begin
		fail_count++;
		$error("imem_req dropped before imem_ack");
	end

	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		imem_req |=> !imem_req || $stable(imem_addr))
	else
	begin
		fail_count++;
		$error("imem_addr changed while imem_req was high");
	end

	// A broadcast must target a live entry that has no result yet
	cdb_pending: assert property (@(posedge clk) disable iff (!rst_n)
		cdb.valid |-> rob_valid[cdb.tag] && !rob_done[cdb.tag])
	else
	begin
		fail_count++;
		$error("CDB broadcast to a free or already finished ROB entry");
	end

	commit_known: assert property (@(posedge clk) disable iff (!rst_n)
		commit.valid |-> !$isunknown(commit.value))
	else
	begin
		fail_count++;
		$error("Commit carries an unknown value");
	end

endmodule

/* test/cpu_datapath_tb.sv */
`timescale 1ns/100ps

module cpu_datapath_tb
	import lc3b_pkg::*;
();

	localparam int prog_len = 64;
	localparam int timeout_cycles = prog_len * 40;
	localparam lc3b_word nop_word = 16'h1020;

	logic clk = 1'b0;
	logic rst_n;
	logic imem_req;
	lc3b_word imem_addr;
	lc3b_word imem_rdata;
	logic imem_ack;
	commit_t commit;

	lc3b_word prog [prog_len];
	commit_t exp_q [$];
	logic [31:0] rng = 32'h331631fe;
	int errors = 0;
	int commit_count = 0;
	int cycles = 0;
	int total;

	bind cpu_datapath cpu_datapath_assertions assertions_i (
		.clk, .rst_n, .imem_req, .imem_ack, .imem_addr, .cdb, .commit,
		.rob_valid(rob_i.valid), .rob_done(rob_i.done)
	);

	cpu_datapath dut_i (
		.clk, .rst_n, .imem_req, .imem_addr, .imem_rdata, .imem_ack, .commit
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Random program over R0..R3, with the in-order result of each instruction queued
	task automatic build_program();
		lc3b_word regs [8];
		lc3b_reg dr, sa, sb;
		lc3b_word a, b, r, imm;
		logic use_imm;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		for (int i = 0; i < prog_len; i++)
		begin
			rng = xorshift(rng);
			dr = {1'b0, rng[3:2]};
			sa = {1'b0, rng[5:4]};
			sb = {1'b0, rng[7:6]};
			use_imm = rng[14];
			imm = {{11{rng[12]}}, rng[12:8]};
			a = regs[sa];
			b = use_imm ? imm : regs[sb];
			case (rng[1:0])
				2'd2:
				begin
					prog[i] = use_imm ? {4'b0101, dr, sa, 1'b1, rng[12:8]}
						: {4'b0101, dr, sa, 3'b000, sb};
					r = a & b;
				end
				2'd3:
				begin
					prog[i] = {4'b1001, dr, sa, 6'h3f};
					r = ~a;
				end
				default:
				begin
					prog[i] = use_imm ? {4'b0001, dr, sa, 1'b1, rng[12:8]}
						: {4'b0001, dr, sa, 3'b000, sb};
					r = a + b;
				end
			endcase
			regs[dr] = r;
			exp_q.push_back('{valid: 1'b1, dest: dr, value: r});
		end
	endtask

	// Instruction memory with random ack delays on both phases
	initial
	begin : imem_responder
		int delay;
		@(posedge rst_n);
		forever
		begin
			@(negedge clk);
			if (imem_req)
			begin
				rng = xorshift(rng);
				delay = rng[1:0];
				repeat (delay) @(negedge clk);
				imem_rdata = (imem_addr[15:1] < prog_len) ? prog[imem_addr[6:1]] : nop_word;
				imem_ack = 1'b1;
				do @(negedge clk); while (imem_req);
				rng = xorshift(rng);
				delay = rng[1:0];
				repeat (delay) @(negedge clk);
				imem_ack = 1'b0;
			end
		end
	end

	// Padding commits past the program are not compared
	always @(negedge clk)
	begin
		if (rst_n && commit.valid && commit_count < prog_len)
		begin
			assert (commit.dest == exp_q[0].dest && commit.value == exp_q[0].value)
			else
			begin
				errors++;
				$display("Error at %0t: commit %0d wrote R%0d = %h, expected R%0d = %h",
					$time, commit_count, commit.dest, commit.value,
					exp_q[0].dest, exp_q[0].value);
			end
			void'(exp_q.pop_front());
			commit_count++;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		imem_ack = 1'b0;
		imem_rdata = '0;
		build_program();
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		assert (!imem_req && !commit.valid)
		else
		begin
			errors++;
			$display("Error at %0t: imem_req or commit.valid high right after reset", $time);
		end
		while (commit_count < prog_len && cycles < timeout_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		if (commit_count < prog_len)
			$display("Timeout: only %0d of %0d instructions committed in %0d cycles",
				commit_count, prog_len, timeout_cycles);
		total = errors + dut_i.assertions_i.fail_count;
		$display("Errors: %0d commit checks, %0d assertions, %0d of %0d commits",
			errors, dut_i.assertions_i.fail_count, commit_count, prog_len);
		if (total == 0 && commit_count == prog_len)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* vlog.f */
rtl/lc3b_pkg.sv
rtl/fetch_unit.sv
rtl/issue_control.sv
rtl/regfile.sv
rtl/alu_rs_unit.sv
rtl/reorder_buffer.sv
rtl/cpu_datapath.sv
test/cpu_datapath_assertions.sv
test/cpu_datapath_tb.sv

/* Bender.yml */
package:
  name: lc3b_ooo_core

sources:
  - rtl/lc3b_pkg.sv
  - rtl/fetch_unit.sv
  - rtl/issue_control.sv
  - rtl/regfile.sv
  - rtl/alu_rs_unit.sv
  - rtl/reorder_buffer.sv
  - rtl/cpu_datapath.sv
  - target: test
    files:
      - test/cpu_datapath_assertions.sv
      - test/cpu_datapath_tb.sv
